//--- hdl/capture_pkg.sv
package capture_pkg;

    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 32;
    localparam int PIXEL_W         = 24;
    localparam int BURST_LEN       = 16;
    localparam logic [ADDR_W-1:0] BUF0_BASE = 32'h0;
    localparam logic [ADDR_W-1:0] BUF1_BASE = 32'h100_0000;
    localparam int MAX_FRAME_WORDS = 4096;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [3:0]         beat_cnt_t;
    typedef logic [12:0]        word_cnt_t;

    typedef struct packed {
        addr_t addr;
    } burst_cmd_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } wbeat_t;

    // AXI4 channel payloads, INCR bursts of 4-byte beats
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } axi_aw_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } axi_ar_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_RUN,
        DRAIN
    } ctrl_state_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_t;

endpackage

//--- hdl/frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl import capture_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      vsync_i,
    input  logic      recv_enable_i,
    input  word_t     recv_data_i,
    output logic      recv_ack_o,
    output addr_t     wr_base_o,
    output logic      rd_start_o,
    output addr_t     rd_base_o,
    output word_cnt_t rd_words_o,
    input  logic      rd_done_i
);

    ctrl_state_t state;
    logic        frame_select;
    logic        done_sel;
    logic        wr_sel;
    logic        cmd_ok;
    logic        cmd_take;

    // Word count must be a nonzero whole number of bursts
    assign cmd_ok = (recv_data_i != '0)
                 && (recv_data_i[3:0] == 4'h0)
                 && (recv_data_i <= word_t'(MAX_FRAME_WORDS));

    assign recv_ack_o = (state == IDLE);
    assign cmd_take   = recv_enable_i && recv_ack_o && cmd_ok;
    assign rd_start_o = (state == READ_RUN);

    assign wr_base_o = wr_sel ? BUF1_BASE : BUF0_BASE;
    assign rd_base_o = frame_select ? BUF1_BASE : BUF0_BASE;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state        <= IDLE;
            frame_select <= 1'b0;
            done_sel     <= 1'b0;
            wr_sel       <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_take) begin
                        state <= READ_RUN;
                    end
                end
                READ_RUN: state <= DRAIN;
                // Reader reports done once the sender is empty
                DRAIN: begin
                    if (rd_done_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (cmd_take) begin
                frame_select <= done_sel;
            end

            // Writer never lands on the buffer being read back
            if (vsync_i) begin
                done_sel <= wr_sel;
                wr_sel   <= ~(cmd_take ? done_sel : frame_select);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_take) begin
            rd_words_o <= word_cnt_t'(recv_data_i);
        end
    end

endmodule

//--- hdl/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer import capture_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       vsync_i,
    input  logic       de_i,
    input  pixel_t     rgb_i,
    input  addr_t      wr_base_i,
    output burst_cmd_t cmd_o,
    output logic       cmd_valid_o,
    input  logic       cmd_ready_i,
    output wbeat_t     beat_o,
    output logic       beat_valid_o,
    input  logic       beat_ready_i
);

    // Staging for two full bursts
    wbeat_t     beat_mem [2*BURST_LEN];
    addr_t      cmd_addr [2];
    logic [5:0] wr_ptr;
    logic [5:0] rd_ptr;
    logic [1:0] grp_wr;
    logic [1:0] grp_cmd;
    word_cnt_t  frame_cnt;
    logic       grp_end;

    assign grp_end = de_i && (frame_cnt[3:0] == 4'hf);

    assign beat_valid_o = (wr_ptr != rd_ptr);
    assign beat_o       = beat_mem[rd_ptr[4:0]];
    assign cmd_valid_o  = (grp_wr != grp_cmd);
    assign cmd_o.addr   = cmd_addr[grp_cmd[0]];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            grp_wr    <= '0;
            grp_cmd   <= '0;
            frame_cnt <= '0;
        end else begin
            if (vsync_i) begin
                frame_cnt <= '0;
            end else if (de_i) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (de_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (beat_valid_o && beat_ready_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (grp_end) begin
                grp_wr <= grp_wr + 1'b1;
            end
            if (cmd_valid_o && cmd_ready_i) begin
                grp_cmd <= grp_cmd + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (de_i) begin
            beat_mem[wr_ptr[4:0]] <= '{data: word_t'(rgb_i), last: (frame_cnt[3:0] == 4'hf)};
        end
        // Burst address is the frame offset of its first word
        if (grp_end) begin
            cmd_addr[grp_wr[0]] <= wr_base_i + addr_t'({frame_cnt[12:4], 6'b0});
        end
    end

endmodule

//--- hdl/axi_burst_writer.sv
`timescale 1ns/1ps

module axi_burst_writer import capture_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  burst_cmd_t cmd_i,
    input  logic       cmd_valid_i,
    output logic       cmd_ready_o,
    input  wbeat_t     beat_i,
    input  logic       beat_valid_i,
    output logic       beat_ready_o,
    output axi_aw_t    aw_o,
    output logic       aw_valid_o,
    input  logic       aw_ready_i,
    output axi_w_t     w_o,
    output logic       w_valid_o,
    input  logic       w_ready_i,
    input  logic       b_valid_i,
    input  logic [1:0] b_resp_i,
    output logic       b_ready_o
);

    wr_state_t state;
    beat_cnt_t beat_cnt;
    addr_t     aw_addr;
    logic      w_fire;

    assign cmd_ready_o = (state == W_IDLE);

    assign aw_o       = '{addr: aw_addr, len: 8'(BURST_LEN - 1)};
    assign aw_valid_o = (state == W_ADDR);

    // Beats come straight from the staging buffer, which holds them until taken
    assign w_o          = '{data: beat_i.data, strb: 4'hf, last: beat_i.last};
    assign w_valid_o    = (state == W_DATA) && beat_valid_i;
    assign beat_ready_o = (state == W_DATA) && w_ready_i;
    assign w_fire       = w_valid_o && w_ready_i;

    assign b_ready_o = (state == W_RESP);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= W_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (cmd_valid_i) begin
                        state <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (aw_ready_i) begin
                        state    <= W_DATA;
                        beat_cnt <= '0;
                    end
                end
                W_DATA: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == beat_cnt_t'(BURST_LEN - 1)) begin
                            state <= W_RESP;
                        end
                    end
                end
                // Response code is not acted on, one burst at a time
                W_RESP: begin
                    if (b_valid_i) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && cmd_ready_o) begin
            aw_addr <= cmd_i.addr;
        end
    end

endmodule

//--- hdl/axi_burst_reader.sv
`timescale 1ns/1ps

module axi_burst_reader import capture_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      start_i,
    input  addr_t     base_i,
    input  word_cnt_t words_i,
    output logic      done_o,
    output axi_ar_t   ar_o,
    output logic      ar_valid_o,
    input  logic      ar_ready_i,
    input  axi_r_t    r_i,
    input  logic      r_valid_i,
    output logic      r_ready_o,
    output word_t     data_o,
    output logic      data_valid_o,
    input  logic      data_ready_i,
    input  logic      buf_empty_i
);

    logic      busy;
    logic      in_burst;
    word_cnt_t remain;
    addr_t     next_addr;
    logic      idle_slot;

    assign ar_o = '{addr: next_addr, len: 8'(BURST_LEN - 1)};

    assign data_o       = r_i.data;
    assign data_valid_o = r_valid_i && in_burst;
    assign r_ready_o    = data_ready_i && in_burst;

    // Nothing in flight and the sender has room for a whole burst
    assign idle_slot = busy && !ar_valid_o && !in_burst && buf_empty_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy       <= 1'b0;
            in_burst   <= 1'b0;
            ar_valid_o <= 1'b0;
            done_o     <= 1'b0;
            remain     <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy   <= 1'b1;
                remain <= words_i;
            end else if (idle_slot) begin
                if (remain != '0) begin
                    ar_valid_o <= 1'b1;
                end else begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end

            if (ar_valid_o && ar_ready_i) begin
                ar_valid_o <= 1'b0;
                in_burst   <= 1'b1;
                remain     <= remain - word_cnt_t'(BURST_LEN);
            end

            if (r_valid_i && r_ready_o && r_i.last) begin
                in_burst <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            next_addr <= base_i;
        end else if (ar_valid_o && ar_ready_i) begin
            next_addr <= next_addr + addr_t'(4 * BURST_LEN);
        end
    end

endmodule

//--- hdl/udp_word_sender.sv
`timescale 1ns/1ps

module udp_word_sender import capture_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  word_t data_i,
    input  logic  data_valid_i,
    output logic  data_ready_o,
    output logic  buf_empty_o,
    output logic  send_request_o,
    output logic  send_enable_o,
    output word_t send_data_o,
    input  logic  send_ack_i
);

    word_t      buf_mem [BURST_LEN];
    logic [3:0] wr_ptr;
    logic [3:0] rd_ptr;
    logic [4:0] count;
    logic       push;
    logic       pop;

    assign buf_empty_o  = (count == '0);
    assign data_ready_o = (count != 5'(BURST_LEN));

    // Request and enable both follow buffer occupancy
    assign send_request_o = !buf_empty_o;
    assign send_enable_o  = !buf_empty_o;
    assign send_data_o    = buf_mem[rd_ptr];

    assign push = data_valid_i && data_ready_o;
    assign pop  = send_enable_o && send_ack_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- hdl/capture_top.sv
`timescale 1ns/1ps

module capture_top import capture_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       vsync_i,
    input  logic       de_i,
    input  pixel_t     rgb_i,
    output axi_aw_t    aw_o,
    output logic       aw_valid_o,
    input  logic       aw_ready_i,
    output axi_w_t     w_o,
    output logic       w_valid_o,
    input  logic       w_ready_i,
    input  logic       b_valid_i,
    input  logic [1:0] b_resp_i,
    output logic       b_ready_o,
    output axi_ar_t    ar_o,
    output logic       ar_valid_o,
    input  logic       ar_ready_i,
    input  axi_r_t     r_i,
    input  logic       r_valid_i,
    output logic       r_ready_o,
    input  logic       recv_request_i,
    input  logic       recv_enable_i,
    input  word_t      recv_data_i,
    output logic       recv_ack_o,
    output logic       send_request_o,
    output logic       send_enable_o,
    output word_t      send_data_o,
    input  logic       send_ack_i
);

    addr_t      wr_base;
    addr_t      rd_base;
    word_cnt_t  rd_words;
    logic       rd_start;
    logic       rd_done;
    burst_cmd_t cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    wbeat_t     beat;
    logic       beat_valid;
    logic       beat_ready;
    word_t      rd_data;
    logic       rd_data_valid;
    logic       rd_data_ready;
    logic       buf_empty;

    // Command words only count inside a receive request
    frame_ctrl u_frame_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .vsync_i       (vsync_i),
        .recv_enable_i (recv_request_i && recv_enable_i),
        .recv_data_i   (recv_data_i),
        .recv_ack_o    (recv_ack_o),
        .wr_base_o     (wr_base),
        .rd_start_o    (rd_start),
        .rd_base_o     (rd_base),
        .rd_words_o    (rd_words),
        .rd_done_i     (rd_done)
    );

    pixel_packer u_pixel_packer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .vsync_i      (vsync_i),
        .de_i         (de_i),
        .rgb_i        (rgb_i),
        .wr_base_i    (wr_base),
        .cmd_o        (cmd),
        .cmd_valid_o  (cmd_valid),
        .cmd_ready_i  (cmd_ready),
        .beat_o       (beat),
        .beat_valid_o (beat_valid),
        .beat_ready_i (beat_ready)
    );

    axi_burst_writer u_axi_burst_writer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cmd_i        (cmd),
        .cmd_valid_i  (cmd_valid),
        .cmd_ready_o  (cmd_ready),
        .beat_i       (beat),
        .beat_valid_i (beat_valid),
        .beat_ready_o (beat_ready),
        .aw_o         (aw_o),
        .aw_valid_o   (aw_valid_o),
        .aw_ready_i   (aw_ready_i),
        .w_o          (w_o),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .b_valid_i    (b_valid_i),
        .b_resp_i     (b_resp_i),
        .b_ready_o    (b_ready_o)
    );

    axi_burst_reader u_axi_burst_reader (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .start_i      (rd_start),
        .base_i       (rd_base),
        .words_i      (rd_words),
        .done_o       (rd_done),
        .ar_o         (ar_o),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .r_i          (r_i),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .data_o       (rd_data),
        .data_valid_o (rd_data_valid),
        .data_ready_i (rd_data_ready),
        .buf_empty_i  (buf_empty)
    );

    udp_word_sender u_udp_word_sender (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .data_i         (rd_data),
        .data_valid_i   (rd_data_valid),
        .data_ready_o   (rd_data_ready),
        .buf_empty_o    (buf_empty),
        .send_request_o (send_request_o),
        .send_enable_o  (send_enable_o),
        .send_data_o    (send_data_o),
        .send_ack_i     (send_ack_i)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset released on a rising edge after 16 cycles
    initial begin
        repeat (16) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

//--- verification/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import capture_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  axi_aw_t    aw_i,
    input  logic       aw_valid_i,
    output logic       aw_ready_o,
    input  axi_w_t     w_i,
    input  logic       w_valid_i,
    output logic       w_ready_o,
    output logic       b_valid_o,
    output logic [1:0] b_resp_o,
    input  logic       b_ready_i,
    input  axi_ar_t    ar_i,
    input  logic       ar_valid_i,
    output logic       ar_ready_o,
    output axi_r_t     r_o,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output int         err_cnt_o
);

    word_t mem [addr_t];
    int    seed;
    int    errs;
    addr_t w_addr;
    int    w_beat;
    logic  w_act;
    addr_t r_addr;
    int    r_beat;
    logic  r_act;

    assign err_cnt_o = errs;
    assign b_resp_o  = 2'b00;

    initial begin
        seed = 32'h519b_295b;
        errs = 0;
    end

    // Unwritten locations read back as a marker built from the address
    function automatic word_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ 32'hdead_beef);
    endfunction

    task automatic field_check(string name, int exp, int act);
        assert (exp == act) else begin
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
            errs = errs + 1;
        end
    endtask

    always @(posedge clk_i or negedge arst_n_i) begin : model_seq
        logic r_fire;
        int   nb;
        if (!arst_n_i) begin
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_o        <= '0;
            w_act      <= 1'b0;
            r_act      <= 1'b0;
            w_beat     <= 0;
            r_beat     <= 0;
        end else begin
            r_fire = r_valid_o && r_ready_i;
            nb     = r_beat + (r_fire ? 1 : 0);

            aw_ready_o <= !w_act && !b_valid_o && (($random(seed) & 3) != 0);
            w_ready_o  <= (($random(seed) & 3) != 0);
            ar_ready_o <= !r_act && (($random(seed) & 3) != 0);

            if (aw_valid_i && aw_ready_o) begin
                field_check("aw_len", 15, int'(aw_i.len));
                field_check("aw_addr_low_bits", 0, int'(aw_i.addr[5:0]));
                w_addr     <= aw_i.addr;
                w_beat     <= 0;
                w_act      <= 1'b1;
                aw_ready_o <= 1'b0;
            end

            if (w_valid_i && w_ready_o) begin
                assert (w_act) else begin
                    $display("W beat arrived with no open write burst");
                    errs = errs + 1;
                end
                field_check("w_strb", 15, int'(w_i.strb));
                field_check("w_last", (w_beat == 15) ? 1 : 0, int'(w_i.last));
                mem[w_addr + addr_t'(4 * w_beat)] = w_i.data;
                w_beat <= w_beat + 1;
                if (w_beat == 15) begin
                    w_act     <= 1'b0;
                    b_valid_o <= 1'b1;
                end
            end

            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
            end

            if (ar_valid_i && ar_ready_o) begin
                field_check("ar_len", 15, int'(ar_i.len));
                field_check("ar_addr_low_bits", 0, int'(ar_i.addr[5:0]));
                r_addr     <= ar_i.addr;
                r_beat     <= 0;
                r_act      <= 1'b1;
                ar_ready_o <= 1'b0;
            end

            if (r_fire) begin
                r_beat <= nb;
            end
            // Present the next beat with random gaps, holding it until taken
            if (r_act && nb == 16) begin
                r_act     <= 1'b0;
                r_valid_o <= 1'b0;
            end else if (r_act && (!r_valid_o || r_fire)) begin
                if (($random(seed) & 3) != 0) begin
                    r_valid_o <= 1'b1;
                    r_o <= '{data: read_word(r_addr + addr_t'(4 * nb)), resp: 2'b00,
                             last: (nb == 15)};
                end else begin
                    r_valid_o <= 1'b0;
                end
            end
        end
    end

endmodule

//--- verification/capture_tb.sv
`timescale 1ns/1ps

module capture_tb import capture_pkg::*; ;

    localparam int FRAME_WORDS = 64;
    localparam int TIMEOUT     = 20000;

    logic       clk;
    logic       arst_n;
    logic       vsync;
    logic       de;
    pixel_t     rgb;
    axi_aw_t    aw;
    logic       aw_valid;
    logic       aw_ready;
    axi_w_t     w;
    logic       w_valid;
    logic       w_ready;
    logic       b_valid;
    logic [1:0] b_resp;
    logic       b_ready;
    axi_ar_t    ar;
    logic       ar_valid;
    logic       ar_ready;
    axi_r_t     r;
    logic       r_valid;
    logic       r_ready;
    logic       recv_request;
    logic       recv_enable;
    word_t      recv_data;
    logic       recv_ack;
    logic       send_request;
    logic       send_enable;
    word_t      send_data;
    logic       send_ack;
    int         mem_errs;

    int     seed;
    int     errors;
    int     checks;
    logic   aborted;
    int     b_count;
    pixel_t frames [2][FRAME_WORDS];

    tb_clock_gen CLK (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    capture_top DUT (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .vsync_i        (vsync),
        .de_i           (de),
        .rgb_i          (rgb),
        .aw_o           (aw),
        .aw_valid_o     (aw_valid),
        .aw_ready_i     (aw_ready),
        .w_o            (w),
        .w_valid_o      (w_valid),
        .w_ready_i      (w_ready),
        .b_valid_i      (b_valid),
        .b_resp_i       (b_resp),
        .b_ready_o      (b_ready),
        .ar_o           (ar),
        .ar_valid_o     (ar_valid),
        .ar_ready_i     (ar_ready),
        .r_i            (r),
        .r_valid_i      (r_valid),
        .r_ready_o      (r_ready),
        .recv_request_i (recv_request),
        .recv_enable_i  (recv_enable),
        .recv_data_i    (recv_data),
        .recv_ack_o     (recv_ack),
        .send_request_o (send_request),
        .send_enable_o  (send_enable),
        .send_data_o    (send_data),
        .send_ack_i     (send_ack)
    );

    axi_mem_model MEM (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_valid_o  (b_valid),
        .b_resp_o   (b_resp),
        .b_ready_i  (b_ready),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .err_cnt_o  (mem_errs)
    );

    always @(posedge clk) begin
        if (b_valid && b_ready) begin
            b_count <= b_count + 1;
        end
    end

    task automatic check_word(string name, word_t exp, word_t act);
        checks = checks + 1;
        assert (act == exp) else begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic report_test(string name, int err_before);
        $display("test %-16s %s", name, (errors == err_before) ? "ok" : "had errors");
    endtask

    task automatic give_up(string what);
        $display("Timeout while waiting for %s", what);
        errors  = errors + 1;
        aborted = 1'b1;
    endtask

    task automatic pulse_vsync();
        @(posedge clk);
        vsync <= 1'b1;
        @(posedge clk);
        vsync <= 1'b0;
    endtask

    // Four lines of 16 pixels, 32 idle cycles after each line
    task automatic drive_frame(int f);
        pixel_t pix;
        pulse_vsync();
        for (int line = 0; line < FRAME_WORDS / 16; line++) begin
            for (int p = 0; p < 16; p++) begin
                pix = pixel_t'($random(seed));
                frames[f][line * 16 + p] = pix;
                de  <= 1'b1;
                rgb <= pix;
                @(posedge clk);
            end
            de <= 1'b0;
            repeat (32) @(posedge clk);
        end
    endtask

    task automatic wait_writes(int target);
        int n;
        n = 0;
        while (b_count < target && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (b_count < target) begin
            give_up("write responses");
        end
    endtask

    task automatic check_buffer(int f, addr_t base, string name);
        for (int k = 0; k < FRAME_WORDS; k++) begin
            check_word(name, {8'h00, frames[f][k]}, MEM.read_word(base + addr_t'(4 * k)));
        end
    endtask

    task automatic read_back(int f, bit stall, string name);
        int n;
        int got;
        n = 0;
        while (!recv_ack && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!recv_ack) begin
            give_up("recv_ack before a command");
            return;
        end
        recv_request <= 1'b1;
        recv_enable  <= 1'b1;
        recv_data    <= word_t'(FRAME_WORDS);
        @(posedge clk);
        recv_request <= 1'b0;
        recv_enable  <= 1'b0;
        got = 0;
        n   = 0;
        while (n < TIMEOUT && !(got >= FRAME_WORDS && recv_ack)) begin
            send_ack <= stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(posedge clk);
            n++;
            if (send_enable && send_ack) begin
                // A word on the port means the sender holds data
                check_word({name, "_request"}, 1, word_t'(send_request));
                if (got < FRAME_WORDS) begin
                    check_word(name, {8'h00, frames[f][got]}, send_data);
                end else begin
                    $display("Extra word %h sent after the whole frame", send_data);
                    errors = errors + 1;
                end
                got++;
            end
        end
        send_ack <= 1'b1;
        if (got < FRAME_WORDS || !recv_ack) begin
            give_up("the read-back to finish");
        end else begin
            check_word({name, "_request_idle"}, 0, word_t'(send_request));
        end
    endtask

    initial begin
        int e0;
        int n;
        seed         = 32'h519b_295b;
        errors       = 0;
        checks       = 0;
        aborted      = 1'b0;
        b_count      = 0;
        vsync        = 1'b0;
        de           = 1'b0;
        rgb          = '0;
        recv_request = 1'b0;
        recv_enable  = 1'b0;
        recv_data    = '0;
        send_ack     = 1'b1;

        n = 0;
        while (!arst_n && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!arst_n) begin
            give_up("reset release");
        end

        if (!aborted) begin
            e0 = errors;
            check_word("reset_aw_valid", 0, word_t'(aw_valid));
            check_word("reset_w_valid", 0, word_t'(w_valid));
            check_word("reset_ar_valid", 0, word_t'(ar_valid));
            check_word("reset_send_request", 0, word_t'(send_request));
            check_word("reset_send_enable", 0, word_t'(send_enable));
            check_word("reset_recv_ack", 1, word_t'(recv_ack));
            report_test("reset_values", e0);
        end

        if (!aborted) begin
            e0 = errors;
            drive_frame(0);
            wait_writes(FRAME_WORDS / 16);
            check_buffer(0, BUF1_BASE, "frame_a_buf1");
            report_test("frame_to_buf1", e0);
        end

        if (!aborted) begin
            e0 = errors;
            pulse_vsync();
            read_back(0, 1'b0, "readback_a");
            report_test("readback", e0);
        end

        // Buffer 1 is now selected, so the next frame lands in buffer 0
        if (!aborted) begin
            e0 = errors;
            drive_frame(1);
            wait_writes(FRAME_WORDS / 8);
            check_buffer(1, BUF0_BASE, "frame_b_buf0");
            check_buffer(0, BUF1_BASE, "frame_a_kept");
            report_test("frame_to_buf0", e0);
        end

        if (!aborted) begin
            e0 = errors;
            pulse_vsync();
            read_back(1, 1'b1, "readback_b_stall");
            report_test("readback_stall", e0);
        end

        $display("test %-16s %s", "axi_burst_fields", (mem_errs == 0) ? "ok" : "had errors");
        $display("checks %0d, testbench errors %0d, memory model errors %0d",
                 checks, errors, mem_errs);
        if (errors == 0 && mem_errs == 0 && !aborted) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/capture_pkg.sv
hdl/frame_ctrl.sv
hdl/pixel_packer.sv
hdl/axi_burst_writer.sv
hdl/axi_burst_reader.sv
hdl/udp_word_sender.sv
hdl/capture_top.sv
verification/tb_clock_gen.sv
verification/axi_mem_model.sv
verification/capture_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := capture_tb
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
